// ==== design/nlms_fmt_pkg.sv ====
package nlms_fmt_pkg;

    // Reference samples and the error share one format.
    localparam int SAMPLE_W = 14;
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    localparam int WEIGHT_W = 16;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    localparam weight_t WEIGHT_MAX = {1'b0, {(WEIGHT_W-1){1'b1}}};
    localparam weight_t WEIGHT_MIN = {1'b1, {(WEIGHT_W-1){1'b0}}};

    localparam int PRODUCT_W = 2 * SAMPLE_W + 1;
    typedef logic signed [PRODUCT_W-1:0] product_t;

    // The product is scaled down by 2^7 before the division.
    localparam int PROD_SHIFT = 7;
    localparam int DIVIDEND_W = PRODUCT_W - PROD_SHIFT;
    typedef logic signed [DIVIDEND_W-1:0] dividend_t;

    localparam int POWER_W = 32;
    typedef logic [POWER_W-1:0] power_t;

    // The input power is scaled down by 2^15.
    localparam int POWER_SHIFT = 15;
    localparam int DIVISOR_W = POWER_W - POWER_SHIFT;
    typedef logic [DIVISOR_W-1:0] divisor_t;

    localparam int QUOTIENT_W = DIVIDEND_W;
    typedef logic signed [QUOTIENT_W-1:0] quotient_t;

endpackage

// ==== design/nlms_ctrl_pkg.sv ====
package nlms_ctrl_pkg;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_DIVIDE,
        SEQ_WRITE
    } seq_state_t;

    // One restoring step per bit of the dividend magnitude.
    localparam int DIV_CYCLES = nlms_fmt_pkg::DIVIDEND_W;

    // Load, divide start, the divider steps and the write cycle.
    localparam int TAP_CYCLES = DIV_CYCLES + 3;

endpackage

// ==== design/tap_delay_line.sv ====
`timescale 1ns/1ps

module tap_delay_line #(
    parameter int NUM_TAPS = 32
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        sample_valid,
    input  nlms_fmt_pkg::sample_t       sample,
    input  logic                        busy,
    input  logic [$clog2(NUM_TAPS)-1:0] tap_idx,
    output nlms_fmt_pkg::sample_t       tap_sample
);
    import nlms_fmt_pkg::*;

    sample_t taps [NUM_TAPS];

    // Tap 0 always holds the newest sample.
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < NUM_TAPS; i++)
            begin
                taps[i] <= '0;
            end
        end
        else if (sample_valid && !busy) // Frozen while a round reads the taps.
        begin
            for (int i = NUM_TAPS - 1; i > 0; i--)
            begin
                taps[i] <= taps[i-1];
            end
            taps[0] <= sample;
        end
    end

    assign tap_sample = taps[tap_idx];

    tap_idx_in_range : assert property (
        @(posedge clk) disable iff (!rstn) tap_idx < NUM_TAPS
    ) else $error("tap_delay_line: tap_idx %0d out of range", tap_idx);

endmodule

// ==== design/tap_update_sequencer.sv ====
`timescale 1ns/1ps

module tap_update_sequencer #(
    parameter int NUM_TAPS = 32
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        start,
    input  nlms_fmt_pkg::sample_t       err,
    input  nlms_fmt_pkg::power_t        power,
    input  nlms_fmt_pkg::sample_t       tap_sample,
    input  logic                        div_done,
    output logic [$clog2(NUM_TAPS)-1:0] tap_idx,
    output logic                        div_start,
    output nlms_fmt_pkg::dividend_t     dividend,
    output nlms_fmt_pkg::divisor_t      divisor,
    output logic                        wr_en,
    output logic [$clog2(NUM_TAPS)-1:0] wr_idx,
    output nlms_fmt_pkg::quotient_t     delta,
    input  nlms_fmt_pkg::quotient_t     quotient,
    output logic                        busy,
    output logic                        done
);
    import nlms_fmt_pkg::*;
    import nlms_ctrl_pkg::*;

    localparam int IDX_W = $clog2(NUM_TAPS);

    seq_state_t state;
    sample_t    err_q;
    power_t     power_q;
    product_t   product;
    logic       last_tap;
    logic       accept;

    assign product  = product_t'(err_q) * product_t'(tap_sample);
    assign last_tap = (tap_idx == IDX_W'(NUM_TAPS - 1));

    // The last write cycle already counts as free, so a new round can follow
    // back to back and the round length stays NUM_TAPS * TAP_CYCLES.
    assign done   = (state == SEQ_WRITE) && last_tap;
    assign busy   = (state != SEQ_IDLE) && !done;
    assign accept = start && !busy;

    assign wr_en  = (state == SEQ_WRITE);
    assign wr_idx = tap_idx;
    assign delta  = quotient;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state     <= SEQ_IDLE;
            tap_idx   <= '0;
            div_start <= 1'b0;
        end
        else
        begin
            div_start <= (state == SEQ_LOAD); // Operands are registered by now.
            case (state)
                SEQ_IDLE:
                begin
                    if (accept)
                    begin
                        state <= SEQ_LOAD;
                    end
                end
                SEQ_LOAD:
                begin
                    state <= SEQ_DIVIDE;
                end
                SEQ_DIVIDE:
                begin
                    if (div_done)
                    begin
                        state <= SEQ_WRITE;
                    end
                end
                SEQ_WRITE:
                begin
                    if (!last_tap)
                    begin
                        tap_idx <= tap_idx + 1'b1;
                        state   <= SEQ_LOAD;
                    end
                    else
                    begin
                        tap_idx <= '0;
                        state   <= accept ? SEQ_LOAD : SEQ_IDLE;
                    end
                end
                default:
                begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Error and power are held for the whole round.
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            err_q   <= err;
            power_q <= power;
        end
        if (state == SEQ_LOAD)
        begin
            dividend <= dividend_t'(product >>> PROD_SHIFT);
            divisor  <= divisor_t'(power_q >> POWER_SHIFT);
        end
    end

    no_div_done_idle : assert property (
        @(posedge clk) disable iff (!rstn) div_done |-> state != SEQ_IDLE
    ) else $error("tap_update_sequencer: div_done while idle");

    done_one_cycle : assert property (
        @(posedge clk) disable iff (!rstn) done |=> !done
    ) else $error("tap_update_sequencer: done held longer than one cycle");

endmodule

// ==== design/signed_divider.sv ====
`timescale 1ns/1ps

module signed_divider (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    div_start,
    input  nlms_fmt_pkg::dividend_t dividend,
    input  nlms_fmt_pkg::divisor_t  divisor,
    output logic                    div_done,
    output nlms_fmt_pkg::quotient_t quotient
);
    import nlms_fmt_pkg::*;
    import nlms_ctrl_pkg::*;

    localparam int MAG_W = DIVIDEND_W;
    localparam int CNT_W = $clog2(DIV_CYCLES + 1);

    logic             active;
    logic [CNT_W-1:0] cnt;
    logic             neg_q;
    logic             zero_q;
    divisor_t         dvs_q;
    logic [MAG_W-1:0] num_q;
    divisor_t         rem_q;

    logic [MAG_W-1:0]   num_src;
    divisor_t           rem_src;
    divisor_t           dvs_src;
    logic [DIVISOR_W:0] trial;
    logic [DIVISOR_W:0] diff;
    logic [MAG_W-1:0]   num_next;
    divisor_t           rem_next;
    quotient_t          result;

    // The first step runs in the div_start cycle straight from the inputs,
    // which puts div_done exactly DIV_CYCLES cycles later.
    always_comb
    begin
        if (div_start)
        begin
            num_src = dividend[DIVIDEND_W-1] ? $unsigned(-dividend) : $unsigned(dividend);
            rem_src = '0;
            dvs_src = divisor;
        end
        else
        begin
            num_src = num_q;
            rem_src = rem_q;
            dvs_src = dvs_q;
        end

        trial = {rem_src, num_src[MAG_W-1]};
        diff  = trial - {1'b0, dvs_src};
        if (trial >= {1'b0, dvs_src})
        begin
            rem_next = diff[DIVISOR_W-1:0];
            num_next = {num_src[MAG_W-2:0], 1'b1};
        end
        else
        begin
            rem_next = trial[DIVISOR_W-1:0];
            num_next = {num_src[MAG_W-2:0], 1'b0};
        end
    end

    // Magnitude division then sign, so the result truncates toward zero.
    assign result = zero_q ? '0 : (neg_q ? quotient_t'(-num_next) : quotient_t'(num_next));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            active   <= 1'b0;
            cnt      <= '0;
            div_done <= 1'b0;
        end
        else
        begin
            div_done <= 1'b0;
            if (div_start)
            begin
                active <= 1'b1;
                cnt    <= CNT_W'(DIV_CYCLES - 1);
            end
            else if (active)
            begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1))
                begin
                    active   <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (div_start || active)
        begin
            num_q <= num_next; // Quotient bits shift in from the right.
            rem_q <= rem_next;
        end
        if (div_start)
        begin
            dvs_q  <= divisor;
            neg_q  <= dividend[DIVIDEND_W-1];
            zero_q <= (divisor == '0);
        end
        if (active && cnt == CNT_W'(1))
        begin
            quotient <= result; // Held until the next division ends.
        end
    end

    no_restart : assert property (
        @(posedge clk) disable iff (!rstn) div_start |-> !active
    ) else $error("signed_divider: div_start during a division");

endmodule

// ==== design/weight_bank.sv ====
`timescale 1ns/1ps

module weight_bank #(
    parameter int NUM_TAPS = 32
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        wr_en,
    input  logic [$clog2(NUM_TAPS)-1:0] wr_idx,
    input  nlms_fmt_pkg::quotient_t     delta,
    input  logic [$clog2(NUM_TAPS)-1:0] rd_idx,
    output nlms_fmt_pkg::weight_t       rd_weight
);
    import nlms_fmt_pkg::*;

    // One guard bit above the wider operand keeps the sum exact.
    localparam int SUM_W = ((QUOTIENT_W > WEIGHT_W) ? QUOTIENT_W : WEIGHT_W) + 1;

    weight_t                 weights [NUM_TAPS];
    logic signed [SUM_W-1:0] sum;
    weight_t                 sat;

    assign sum = SUM_W'(weights[wr_idx]) + SUM_W'(delta);

    always_comb
    begin
        if (sum > SUM_W'(WEIGHT_MAX))
        begin
            sat = WEIGHT_MAX;
        end
        else if (sum < SUM_W'(WEIGHT_MIN))
        begin
            sat = WEIGHT_MIN;
        end
        else
        begin
            sat = weight_t'(sum);
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < NUM_TAPS; i++)
            begin
                weights[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            weights[wr_idx] <= sat;
        end
    end

    assign rd_weight = weights[rd_idx];

    wr_idx_in_range : assert property (
        @(posedge clk) disable iff (!rstn) wr_en |-> wr_idx < NUM_TAPS
    ) else $error("weight_bank: wr_idx %0d out of range", wr_idx);

endmodule

// ==== design/nlms_weight_update.sv ====
`timescale 1ns/1ps

module nlms_weight_update #(
    parameter int NUM_TAPS = 32
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        sample_valid,
    input  nlms_fmt_pkg::sample_t       sample,
    input  logic                        start,
    input  nlms_fmt_pkg::sample_t       err,
    input  nlms_fmt_pkg::power_t        power,
    input  logic [$clog2(NUM_TAPS)-1:0] rd_idx,
    output logic                        busy,
    output logic                        done,
    output nlms_fmt_pkg::weight_t       rd_weight
);
    import nlms_fmt_pkg::*;

    localparam int IDX_W = $clog2(NUM_TAPS);

    logic [IDX_W-1:0] tap_idx;
    sample_t          tap_sample;
    logic             div_start;
    dividend_t        dividend;
    divisor_t         divisor;
    logic             div_done;
    quotient_t        quotient;
    logic             wr_en;
    logic [IDX_W-1:0] wr_idx;
    quotient_t        delta;

    tap_delay_line #(
        .NUM_TAPS (NUM_TAPS)
    ) delay_line_i (
        .clk          (clk),
        .rstn         (rstn),
        .sample_valid (sample_valid),
        .sample       (sample),
        .busy         (busy),
        .tap_idx      (tap_idx),
        .tap_sample   (tap_sample)
    );

    tap_update_sequencer #(
        .NUM_TAPS (NUM_TAPS)
    ) sequencer_i (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .err        (err),
        .power      (power),
        .tap_sample (tap_sample),
        .div_done   (div_done),
        .tap_idx    (tap_idx),
        .div_start  (div_start),
        .dividend   (dividend),
        .divisor    (divisor),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .delta      (delta),
        .quotient   (quotient),
        .busy       (busy),
        .done       (done)
    );

    signed_divider divider_i (
        .clk       (clk),
        .rstn      (rstn),
        .div_start (div_start),
        .dividend  (dividend),
        .divisor   (divisor),
        .div_done  (div_done),
        .quotient  (quotient)
    );

    weight_bank #(
        .NUM_TAPS (NUM_TAPS)
    ) bank_i (
        .clk       (clk),
        .rstn      (rstn),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .delta     (delta),
        .rd_idx    (rd_idx),
        .rd_weight (rd_weight)
    );

endmodule

// ==== sim/tb_nlms_weight_update.sv ====
`timescale 1ns/1ps

module tb_nlms_weight_update;
    import nlms_fmt_pkg::*;
    import nlms_ctrl_pkg::*;

    localparam int NUM_TAPS       = 32;
    localparam int IDX_W          = $clog2(NUM_TAPS);
    localparam int CLK_PERIOD     = 100;
    localparam int ROUND_CYCLES   = NUM_TAPS * TAP_CYCLES;
    localparam int ROUND_COUNT    = 16; // Rounds started over all tests.
    localparam int TIMEOUT_CYCLES = ROUND_COUNT * (ROUND_CYCLES + 3 * NUM_TAPS) + 500;

    logic             clk;
    logic             rstn;
    logic             sample_valid;
    sample_t          sample;
    logic             start;
    sample_t          err;
    power_t           power;
    logic [IDX_W-1:0] rd_idx;
    logic             busy;
    logic             done;
    weight_t          rd_weight;

    // Reference model state.
    sample_t ref_taps [NUM_TAPS];
    weight_t ref_weights [NUM_TAPS];
    sample_t pending [$];

    int seed = 32'h3362_59bc;
    int error_count = 0;
    int test_count = 0;
    int errors_at_start = 0;
    int cycle_count = 0;

    nlms_weight_update #(
        .NUM_TAPS (NUM_TAPS)
    ) dut_i (
        .clk          (clk),
        .rstn         (rstn),
        .sample_valid (sample_valid),
        .sample       (sample),
        .start        (start),
        .err          (err),
        .power        (power),
        .rd_idx       (rd_idx),
        .busy         (busy),
        .done         (done),
        .rd_weight    (rd_weight)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles.", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_weight(input weight_t actual, input weight_t expected, input string what);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s read %0d, expected %0d", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected)
        begin
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic mark_test_start();
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic report_test(input string name);
        if (error_count == errors_at_start)
            $display("Test %0d (%s): ok", test_count, name);
        else
            $display("Test %0d (%s): %0d errors", test_count, name, error_count - errors_at_start);
    endtask

    // Each weight moves by (err * tap >>> 7) / (power >> 15) truncated toward zero, then saturates.
    task automatic model_round(input sample_t e, input power_t p);
        longint dvs;
        longint dvd;
        longint sum;
        dvs = longint'(p) >> 15;
        for (int i = 0; i < NUM_TAPS; i++)
        begin
            dvd = (longint'(e) * longint'(ref_taps[i])) >>> 7;
            sum = longint'(ref_weights[i]) + ((dvs == 0) ? 0 : dvd / dvs);
            if (sum > longint'(WEIGHT_MAX))
                sum = longint'(WEIGHT_MAX);
            else if (sum < longint'(WEIGHT_MIN))
                sum = longint'(WEIGHT_MIN);
            ref_weights[i] = weight_t'(sum);
        end
    endtask

    task automatic load_pending();
        while (pending.size() > 0)
        begin
            @(negedge clk);
            sample_valid = 1'b1;
            sample = pending.pop_front();
            for (int k = NUM_TAPS - 1; k > 0; k--)
                ref_taps[k] = ref_taps[k-1];
            ref_taps[0] = sample;
        end
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task automatic read_all_weights();
        for (int i = 0; i < NUM_TAPS; i++)
        begin
            @(negedge clk);
            rd_idx = IDX_W'(i);
            #(CLK_PERIOD / 4);
            check_weight(rd_weight, ref_weights[i], $sformatf("weight %0d", i));
        end
    endtask

    // With disturb set, a stray start and three sample strobes land inside the round.
    task automatic run_round(input sample_t e, input power_t p, input bit disturb);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        @(negedge clk);
        start = 1'b1;
        err = e;
        power = p;
        while (!seen && cycles < 2 * ROUND_CYCLES)
        begin
            @(negedge clk);
            cycles++;
            seen = done;
            if (cycles == 1)
                check_flag(busy, 1'b1, "busy after start");
            start = 1'b0;
            if (disturb && cycles == 10)
            begin
                start = 1'b1;
                err = ~e;
            end
            sample_valid = disturb && (cycles >= 100) && (cycles < 103);
            sample = sample_t'($random(seed));
        end
        if (!seen)
        begin
            $display("Error at %0t ns: done never arrived after start.", $time);
            error_count++;
        end
        check_count(cycles, ROUND_CYCLES, "round length");
        check_flag(busy, 1'b0, "busy in the done cycle");
        model_round(e, p);
        @(negedge clk);
        check_flag(done, 1'b0, "done after its pulse");
        read_all_weights();
    endtask

    task automatic after_reset();
        mark_test_start();
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        read_all_weights();
        report_test("reset");
    endtask

    task automatic single_round();
        mark_test_start();
        for (int i = 0; i < NUM_TAPS; i++)
            pending.push_back(sample_t'(i * 211 + 100));
        load_pending();
        run_round(sample_t'(1500), power_t'(32'h0004_0000), 1'b0);
        report_test("single round");
    endtask

    task automatic signs_and_zero_divisor();
        mark_test_start();
        for (int i = 0; i < NUM_TAPS; i++)
            pending.push_back(sample_t'((i % 3 == 0) ? -(i * 173 + 57) : (i * 149 + 31)));
        load_pending();
        run_round(sample_t'(-3001), power_t'(32'h0003_8123), 1'b0); // Divisor of 7.
        run_round(sample_t'(2000), power_t'(32'h0000_7fff), 1'b0);
        report_test("signs and zero divisor");
    endtask

    task automatic accumulate_to_limits();
        mark_test_start();
        for (int i = 0; i < NUM_TAPS; i++)
            pending.push_back((i % 2 == 0) ? sample_t'(8191) : sample_t'(-8192));
        load_pending();
        repeat (5) run_round(sample_t'(8191), power_t'(32 << 15), 1'b0);
        // The first sample pushed ends up in the last tap, so odd taps hold the positive value.
        for (int i = 0; i < NUM_TAPS; i++)
        begin
            @(negedge clk);
            rd_idx = IDX_W'(i);
            #(CLK_PERIOD / 4);
            check_weight(rd_weight, (i % 2 == 0) ? WEIGHT_MIN : WEIGHT_MAX,
                         $sformatf("saturated weight %0d", i));
        end
        report_test("accumulation and saturation");
    endtask

    task automatic ignore_while_busy();
        mark_test_start();
        run_round(sample_t'(-2500), power_t'(32'h0010_0000), 1'b1);
        run_round(sample_t'(1234), power_t'(32'h0010_0000), 1'b0);
        report_test("inputs ignored while busy");
    endtask

    task automatic random_rounds();
        sample_t e;
        power_t  p;
        mark_test_start();
        for (int r = 0; r < 6; r++)
        begin
            for (int k = 0; k < 5; k++)
                pending.push_back(sample_t'($random(seed)));
            load_pending();
            e = sample_t'($random(seed));
            if (r == 3)
                p = power_t'($random(seed)) & 32'h0000_7fff;
            else
                p = (power_t'($random(seed)) & 32'h00ff_ffff) | 32'h0000_8000;
            run_round(e, p, 1'b0);
        end
        report_test("random rounds");
    endtask

    initial
    begin
        rstn = 1'b0;
        sample_valid = 1'b0;
        sample = '0;
        start = 1'b0;
        err = '0;
        power = '0;
        rd_idx = '0;
        for (int i = 0; i < NUM_TAPS; i++)
        begin
            ref_taps[i] = '0;
            ref_weights[i] = '0;
        end
        repeat (4) @(negedge clk);
        rstn = 1'b1;

        after_reset();
        single_round();
        signs_and_zero_divisor();
        accumulate_to_limits();
        ignore_while_busy();
        random_rounds();

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== nlms_weight_update.f ====
design/nlms_fmt_pkg.sv
design/nlms_ctrl_pkg.sv
design/tap_delay_line.sv
design/tap_update_sequencer.sv
design/signed_divider.sv
design/weight_bank.sv
design/nlms_weight_update.sv
sim/tb_nlms_weight_update.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_nlms_weight_update
FILELIST   := nlms_weight_update.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall
PASS_TEXT  := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run fails unless the testbench prints the pass line.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
